// ==== verilog.f ====
+incdir+include
verilog/rr_pkg.sv
verilog/rr_priority_encoder.sv
verilog/rr_priority_rotator.sv
verilog/e_credit_counter.sv
verilog/e_rr_processor.sv
verilog/e_output_arbiter.sv
test/tb_e_output_arbiter.sv

// ==== run.sh ====
#!/bin/sh
# build and run the east arbiter testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f verilog.f --top-module tb_e_output_arbiter -o tb_sim

# a failing run exits nonzero, the log holds the verdict
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q "No errors" sim.log; then
  echo "simulation ended without a verdict"
  exit 1
fi
echo "simulation passed"

// ==== include/tb_e_output_arbiter_tasks.svh ====
/*
  Tasks included into the arbiter testbench top module.
  They drive and read the DUT signals and model state declared there.
*/

task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
  if (actual !== expected) begin
    error_count++;
    $display("Fail at %0d ns: %s is %0d, expected %0d", $time, what, actual, expected);
    $display("Errors found");
    $fatal(1, "stopped at the first mismatch");
  end
endtask

// galois form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  if (state[0]) begin
    lfsr_next = (state >> 1) ^ 32'h80200003;
  end else begin
    lfsr_next = state >> 1;
  end
endfunction

task automatic random_bits(input int count, output logic [31:0] bits);
  bits = '0;
  for (int i = 0; i < count; i++) begin
    lfsr_state = lfsr_next(lfsr_state);
    bits = {bits[30:0], lfsr_state[0]};
  end
endtask

function automatic port_code_t code_of(input logic [1:0] idx);
  case (idx)
    2'd0:    code_of = PORT_N;
    2'd1:    code_of = PORT_S;
    2'd2:    code_of = PORT_W;
    default: code_of = PORT_L;
  endcase
endfunction

task automatic apply_reset();
  @(negedge clk);
  arst_n_i         = 1'b0;
  n_nexthop_addr_i = PORT_L;
  s_nexthop_addr_i = PORT_L;
  w_nexthop_addr_i = PORT_L;
  l_nexthop_addr_i = PORT_N;
  credit_return_i  = 1'b0;
  repeat (RESET_CYCLES) @(negedge clk);
  arst_n_i     = 1'b1;
  model_ptr    = 2'd0;
  model_credit = CREDIT_SLOTS;
endtask

// one cycle: drive, sample, compare with the model, then advance the model
task automatic drive_cycle(input port_code_t n_a, input port_code_t s_a,
                           input port_code_t w_a, input port_code_t l_a, input logic ret);
  logic [3:0] desire_m;
  logic [3:0] exp_grant;
  port_code_t exp_code;
  logic [1:0] idx;
  logic       found;
  @(negedge clk);
  n_nexthop_addr_i = n_a;
  s_nexthop_addr_i = s_a;
  w_nexthop_addr_i = w_a;
  l_nexthop_addr_i = l_a;
  credit_return_i  = ret;
  #(CLK_PERIOD / 4);
  // model order, bit 0 is north
  desire_m  = {l_a == PORT_E, w_a == PORT_E, s_a == PORT_E, n_a == PORT_E};
  exp_grant = '0;
  exp_code  = PORT_E;
  found     = 1'b0;
  if (model_credit > 0) begin
    for (int i = 0; i < 4; i++) begin
      idx = model_ptr + 2'(i);
      if (!found && desire_m[idx]) begin
        found     = 1'b1;
        exp_grant = 4'b1000 >> idx;
        exp_code  = code_of(idx);
      end
    end
  end
  last_grant = {e_grant_n_o, e_grant_s_o, e_grant_w_o, e_grant_l_o};
  last_code  = e_grant_code_o;
  check_value(32'(last_grant), 32'(exp_grant), "grant vector");
  check_value(32'(last_code), 32'(exp_code), "grant code");
  // state after the coming rising edge
  if (found) begin
    model_ptr = model_ptr + 2'd1;
    if (!ret) begin
      model_credit--;
    end
  end else if (ret && model_credit < CREDIT_SLOTS) begin
    model_credit++;
  end
endtask

task automatic reset_idle_test();
  for (int i = 0; i < IDLE_CYCLES; i++) begin
    drive_cycle(PORT_S, PORT_N, PORT_L, PORT_W, 1'b0);
    check_value(32'(last_grant), 32'd0, "idle grants");
    check_value(32'(last_code), 32'(PORT_E), "idle code");
  end
  // ranks and credit held, so north still wins
  drive_cycle(PORT_E, PORT_E, PORT_E, PORT_E, 1'b1);
  check_value(32'(last_code), 32'(PORT_N), "winner after idle");
endtask

task automatic single_request_test();
  for (int k = 0; k < 4; k++) begin
    drive_cycle(k == 0 ? PORT_E : PORT_L, k == 1 ? PORT_E : PORT_L,
                k == 2 ? PORT_E : PORT_L, k == 3 ? PORT_E : PORT_N, 1'b1);
    check_value(32'(last_grant), 32'(4'b1000 >> k), "single grant");
    check_value(32'(last_code), 32'(code_of(2'(k))), "single code");
  end
  // every other destination, on all inputs at once
  for (int c = 0; c < 8; c++) begin
    if (port_code_t'(c) != PORT_E) begin
      drive_cycle(port_code_t'(c), port_code_t'(c), port_code_t'(c), port_code_t'(c), 1'b0);
      check_value(32'(last_grant), 32'd0, "grant for other port");
    end
  end
endtask

task automatic rotation_test();
  for (int i = 0; i < ROTATE_CYCLES; i++) begin
    drive_cycle(PORT_E, PORT_E, PORT_E, PORT_E, 1'b1);
    check_value(32'(last_code), 32'(code_of(2'(i))), "rotation winner");
  end
endtask

task automatic credit_test();
  int grants;
  grants = 0;
  // two stalls plus the return cycle, so a stray rotation moves the winner
  for (int i = 0; i < CREDIT_SLOTS + 2; i++) begin
    drive_cycle(PORT_E, PORT_E, PORT_E, PORT_E, 1'b0);
    if (|last_grant) begin
      grants++;
    end
  end
  check_value(32'(grants), 32'(CREDIT_SLOTS), "grants without return");
  // return lands while empty, so no grant this cycle
  drive_cycle(PORT_E, PORT_E, PORT_E, PORT_E, 1'b1);
  grants = 0;
  for (int i = 0; i < 3; i++) begin
    drive_cycle(PORT_E, PORT_E, PORT_E, PORT_E, 1'b0);
    if (|last_grant) begin
      grants++;
    end
    if (i == 0) begin
      check_value(32'(last_code), 32'(PORT_N), "winner after stall");
    end
  end
  check_value(32'(grants), 32'd1, "grants after one return");
endtask

task automatic random_test();
  logic [31:0] bits;
  port_code_t  addr [4];
  for (int i = 0; i < RANDOM_CYCLES; i++) begin
    // half the time an input heads east, otherwise any code
    for (int j = 0; j < 4; j++) begin
      random_bits(1, bits);
      if (bits[0]) begin
        addr[j] = PORT_E;
      end else begin
        random_bits(3, bits);
        addr[j] = port_code_t'(bits[2:0]);
      end
    end
    random_bits(1, bits);
    drive_cycle(addr[0], addr[1], addr[2], addr[3], bits[0]);
  end
endtask

// ==== test/tb_e_output_arbiter.sv ====
/*
  Directed testbench for the east output arbiter.
  Inputs change on the falling edge and outputs are sampled a quarter
  period later. A reference model tracks the top-ranked input and the
  downstream credit. The first mismatch ends the run.
*/
`timescale 1ns/1ps

module tb_e_output_arbiter;

  import rr_pkg::*;

  localparam int CLK_PERIOD    = 40;
  localparam int RESET_CYCLES  = 8;
  localparam int CREDIT_SLOTS  = int'(CREDIT_MAX);
  localparam int IDLE_CYCLES   = 6;
  localparam int ROTATE_CYCLES = 8;
  localparam int RANDOM_CYCLES = 200;
  localparam int MARGIN_CYCLES = 20;

  // two resets, idle plus one probe, single requests, rotation, credit, random
  localparam int TEST_CYCLES = 2 * (RESET_CYCLES + 1) + (IDLE_CYCLES + 1) + 11 +
                               ROTATE_CYCLES + (CREDIT_SLOTS + 6) + RANDOM_CYCLES;
  localparam int TIMEOUT_NS  = (TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

  logic       clk;
  logic       arst_n_i;
  port_code_t n_nexthop_addr_i;
  port_code_t s_nexthop_addr_i;
  port_code_t w_nexthop_addr_i;
  port_code_t l_nexthop_addr_i;
  logic       credit_return_i;
  logic       e_grant_n_o;
  logic       e_grant_s_o;
  logic       e_grant_w_o;
  logic       e_grant_l_o;
  port_code_t e_grant_code_o;

  // reference model, pointer 0..3 walks north, south, west, local
  logic [1:0]  model_ptr;
  int          model_credit;
  int          error_count;
  logic [31:0] lfsr_state;

  // last sampled DUT response, grants packed north down to local
  logic [3:0] last_grant;
  port_code_t last_code;

  e_output_arbiter e_output_arbiter_i (
    .clk              (clk),
    .arst_n_i         (arst_n_i),
    .n_nexthop_addr_i (n_nexthop_addr_i),
    .s_nexthop_addr_i (s_nexthop_addr_i),
    .w_nexthop_addr_i (w_nexthop_addr_i),
    .l_nexthop_addr_i (l_nexthop_addr_i),
    .credit_return_i  (credit_return_i),
    .e_grant_n_o      (e_grant_n_o),
    .e_grant_s_o      (e_grant_s_o),
    .e_grant_w_o      (e_grant_w_o),
    .e_grant_l_o      (e_grant_l_o),
    .e_grant_code_o   (e_grant_code_o)
  );

  `include "tb_e_output_arbiter_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: test sequence still running after %0d ns", TIMEOUT_NS);
    $display("Errors found");
    $fatal(1, "watchdog expired");
  end

  initial begin
    arst_n_i         = 1'b1;
    n_nexthop_addr_i = PORT_L;
    s_nexthop_addr_i = PORT_L;
    w_nexthop_addr_i = PORT_L;
    l_nexthop_addr_i = PORT_N;
    credit_return_i  = 1'b0;
    model_ptr        = 2'd0;
    model_credit     = CREDIT_SLOTS;
    error_count      = 0;
    lfsr_state       = 32'd75106;
    last_grant       = '0;
    last_code        = PORT_E;

    apply_reset();
    reset_idle_test();
    single_request_test();
    apply_reset();
    rotation_test();
    credit_test();
    random_test();

    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== verilog/e_output_arbiter.sv ====
/*
  East output port arbiter of a five-port mesh router.
  Grants and e_grant_code_o are combinational from the next-hop codes,
  credit count and rank rows. Ranks rotate and credit drops on the
  edge after a grant. Code is PORT_E while nothing is granted.
*/
`timescale 1ns/1ps

module e_output_arbiter (
  input  logic               clk,
  input  logic               arst_n_i,
  input  rr_pkg::port_code_t n_nexthop_addr_i,
  input  rr_pkg::port_code_t s_nexthop_addr_i,
  input  rr_pkg::port_code_t w_nexthop_addr_i,
  input  rr_pkg::port_code_t l_nexthop_addr_i,
  input  logic               credit_return_i,
  output logic               e_grant_n_o,
  output logic               e_grant_s_o,
  output logic               e_grant_w_o,
  output logic               e_grant_l_o,
  output rr_pkg::port_code_t e_grant_code_o
);

  logic credit_avail;
  logic grant_taken;

  e_rr_processor e_rr_processor_i (
    .clk              (clk),
    .arst_n_i         (arst_n_i),
    .n_nexthop_addr_i (n_nexthop_addr_i),
    .s_nexthop_addr_i (s_nexthop_addr_i),
    .w_nexthop_addr_i (w_nexthop_addr_i),
    .l_nexthop_addr_i (l_nexthop_addr_i),
    .change_order_i   (grant_taken),
    .credit_avail_i   (credit_avail),
    .grant_n_o        (e_grant_n_o),
    .grant_s_o        (e_grant_s_o),
    .grant_w_o        (e_grant_w_o),
    .grant_l_o        (e_grant_l_o),
    .grant_code_o     (e_grant_code_o)
  );

  // grant bits packed north down to local
  e_credit_counter e_credit_counter_i (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .grant_i         ({e_grant_n_o, e_grant_s_o, e_grant_w_o, e_grant_l_o}),
    .credit_return_i (credit_return_i),
    .credit_avail_o  (credit_avail),
    .grant_taken_o   (grant_taken)
  );

endmodule

// ==== verilog/e_rr_processor.sv ====
/*
  East arbitration block. Grants the east-bound input of highest rank.
  Grants are combinational levels and drop while credit_avail_i is low.
  Ranks rotate after every grant whatever input won, which gives a
  rotating priority rather than a strictly fair round robin.
*/
`timescale 1ns/1ps

module e_rr_processor (
  input  logic               clk,
  input  logic               arst_n_i,
  input  rr_pkg::port_code_t n_nexthop_addr_i,
  input  rr_pkg::port_code_t s_nexthop_addr_i,
  input  rr_pkg::port_code_t w_nexthop_addr_i,
  input  rr_pkg::port_code_t l_nexthop_addr_i,
  input  logic               change_order_i,
  input  logic               credit_avail_i,
  output logic               grant_n_o,
  output logic               grant_s_o,
  output logic               grant_w_o,
  output logic               grant_l_o,
  output rr_pkg::port_code_t grant_code_o
);

  import rr_pkg::*;

  req_vec_t   desire;
  req_vec_t   rank3;
  req_vec_t   rank2;
  req_vec_t   rank1;
  req_vec_t   rank0;
  req_vec_t   row_hit;
  req_vec_t   row_pick;
  req_vec_t   sel_row;
  req_vec_t   winner;
  req_vec_t   grant_vec;
  port_code_t win_code;

  // inputs whose head flit wants to leave east
  assign desire[3] = (n_nexthop_addr_i == PORT_E);
  assign desire[2] = (s_nexthop_addr_i == PORT_E);
  assign desire[1] = (w_nexthop_addr_i == PORT_E);
  assign desire[0] = (l_nexthop_addr_i == PORT_E);

  rr_priority_rotator rotator_i (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .change_order_i (change_order_i),
    .rank3_o        (rank3),
    .rank2_o        (rank2),
    .rank1_o        (rank1),
    .rank0_o        (rank0)
  );

  // one hit bit per rank, highest rank in the north slot
  assign row_hit[3] = |(desire & rank3);
  assign row_hit[2] = |(desire & rank2);
  assign row_hit[1] = |(desire & rank1);
  assign row_hit[0] = |(desire & rank0);

  rr_priority_encoder rank_enc_i (
    .req_i  (row_hit),
    .pick_o (row_pick),
    .code_o ()
  );

  // and-or mux over the rank rows
  assign sel_row = ({4{row_pick[3]}} & rank3) |
                   ({4{row_pick[2]}} & rank2) |
                   ({4{row_pick[1]}} & rank1) |
                   ({4{row_pick[0]}} & rank0);

  rr_priority_encoder win_enc_i (
    .req_i  (sel_row),
    .pick_o (winner),
    .code_o (win_code)
  );

  assign grant_vec = winner & desire & {4{credit_avail_i}};

  assign grant_n_o = grant_vec[3];
  assign grant_s_o = grant_vec[2];
  assign grant_w_o = grant_vec[1];
  assign grant_l_o = grant_vec[0];

  // crossbar select falls back to east when nothing is granted
  assign grant_code_o = (|grant_vec) ? win_code : PORT_E;

endmodule

// ==== verilog/e_credit_counter.sv ====
/*
  Credit count for the downstream east buffer, reset to CREDIT_MAX.
  A grant takes one slot, a credit_return_i pulse gives one back.
  Grant and return in the same cycle cancel. Count saturates at
  zero and at CREDIT_MAX, so a return while full is dropped.
*/
`timescale 1ns/1ps

module e_credit_counter (
  input  logic             clk,
  input  logic             arst_n_i,
  input  rr_pkg::req_vec_t grant_i,
  input  logic             credit_return_i,
  output logic             credit_avail_o,
  output logic             grant_taken_o
);

  import rr_pkg::*;

  credit_cnt_t credit_cnt;

  assign grant_taken_o  = |grant_i;
  assign credit_avail_o = (credit_cnt != '0);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credit_cnt <= CREDIT_MAX;
    end else begin
      case ({grant_taken_o, credit_return_i})
        2'b10: begin
          if (credit_cnt != '0) begin
            credit_cnt <= credit_cnt - 3'd1;
          end
        end
        2'b01: begin
          if (credit_cnt != CREDIT_MAX) begin
            credit_cnt <= credit_cnt + 3'd1;
          end
        end
        // idle or grant with return leaves the count alone
        default: begin
          credit_cnt <= credit_cnt;
        end
      endcase
    end
  end

endmodule

// ==== verilog/rr_priority_rotator.sv ====
/*
  Four one-hot rank rows for the competing inputs.
  Row k names the input holding rank k, rank 3 is the highest.
  All rows rotate one step toward bit 0 on the edge after a
  change-order pulse, so the top rank goes north, south, west, local.
*/
`timescale 1ns/1ps

module rr_priority_rotator (
  input  logic             clk,
  input  logic             arst_n_i,
  input  logic             change_order_i,
  output rr_pkg::req_vec_t rank3_o,
  output rr_pkg::req_vec_t rank2_o,
  output rr_pkg::req_vec_t rank1_o,
  output rr_pkg::req_vec_t rank0_o
);

  import rr_pkg::*;

  req_vec_t rank3_r;
  req_vec_t rank2_r;
  req_vec_t rank1_r;
  req_vec_t rank0_r;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rank3_r <= RANK3_RESET;
      rank2_r <= RANK2_RESET;
      rank1_r <= RANK1_RESET;
      rank0_r <= RANK0_RESET;
    end else if (change_order_i) begin
      // bit 0 wraps around to bit 3
      rank3_r <= {rank3_r[0], rank3_r[3:1]};
      rank2_r <= {rank2_r[0], rank2_r[3:1]};
      rank1_r <= {rank1_r[0], rank1_r[3:1]};
      rank0_r <= {rank0_r[0], rank0_r[3:1]};
    end
  end

  assign rank3_o = rank3_r;
  assign rank2_o = rank2_r;
  assign rank1_o = rank1_r;
  assign rank0_o = rank0_r;

endmodule

// ==== verilog/rr_priority_encoder.sv ====
/*
  Fixed-priority encoder over the four competing inputs.
  Order is north, south, west, local (bit 3 down to bit 0).
  Purely combinational. With no request the pick is zero and the
  code is PORT_E.
*/
`timescale 1ns/1ps

module rr_priority_encoder (
  input  rr_pkg::req_vec_t   req_i,
  output rr_pkg::req_vec_t   pick_o,
  output rr_pkg::port_code_t code_o
);

  import rr_pkg::*;

  always_comb begin
    pick_o = '0;
    code_o = PORT_E;
    if (req_i[3]) begin
      pick_o[3] = 1'b1;
      code_o    = PORT_N;
    end else if (req_i[2]) begin
      pick_o[2] = 1'b1;
      code_o    = PORT_S;
    end else if (req_i[1]) begin
      pick_o[1] = 1'b1;
      code_o    = PORT_W;
    end else if (req_i[0]) begin
      pick_o[0] = 1'b1;
      code_o    = PORT_L;
    end
  end

endmodule

// ==== verilog/rr_pkg.sv ====
/*
  Shared types and constants for the east output arbiter.
  Port codes follow the five-port router numbering.
  East never routes to itself, so PORT_E doubles as the "no grant" code.
  CREDIT_MAX must fit in credit_cnt_t.
*/
package rr_pkg;

  // next-hop port code carried with each head flit
  typedef logic [2:0] port_code_t;

  localparam port_code_t PORT_N = 3'd0;
  localparam port_code_t PORT_S = 3'd1;
  localparam port_code_t PORT_W = 3'd2;
  localparam port_code_t PORT_E = 3'd3;
  localparam port_code_t PORT_L = 3'd4;

  // competing inputs, north in bit 3 down to local in bit 0
  typedef logic [3:0] req_vec_t;

  // free slot count of the downstream input buffer
  typedef logic [2:0] credit_cnt_t;

  localparam credit_cnt_t CREDIT_MAX = 3'd4;

  // reset rows of the rank rotator
  // rank 3 is the highest and starts at north
  localparam req_vec_t RANK3_RESET = 4'b1000;
  localparam req_vec_t RANK2_RESET = 4'b0100;
  localparam req_vec_t RANK1_RESET = 4'b0010;
  localparam req_vec_t RANK0_RESET = 4'b0001;

endpackage
